//--- flist.f
+incdir+design
design/ppuDecodePkg.sv
design/instrClassifier.sv
design/controlEncoder.sv
design/idSkidBuffer.sv
design/ppuDecodeUnit.sv
bench/tb_ppuDecodeUnit.sv

//--- bench/decode_patterns.txt
// columns: instruction word, expected control word, expected unknown flag
// all values in hex, one instruction per line
00000000 0000000 0 // nop
25280005 00A0100 0 // addiu t0, t1, 5
01095021 0100100 0 // addu t2, t0, t1
01095023 0100900 0 // subu t2, t0, t1
83A80004 00A030C 0 // lb t0, 4(sp)
93A80004 00A0304 0 // lbu t0, 4(sp)
A3A80004 0080014 0 // sb t0, 4(sp)
FFA80008 0080014 0 // sd t0, 8(sp)
1D000003 0805480 0 // bgtz t0
11090004 1C00480 0 // beq t0, t1
10000010 1C00480 0 // b
05010008 1C45480 0 // bgez t0
05000008 1C45480 0 // bltz t0
0C100040 06DE180 0 // jal
03E00008 0E40000 0 // jr ra
3C081234 00AD900 0 // lui t0, 0x1234
0109502A 0000000 1 // slt
8FA80004 0000000 1 // lw
00084080 0000000 1 // sll with nonzero fields
21280005 0000000 1 // addi
0109502B 0000000 1 // sltu
2529FFFF 00A0100 0 // addiu t1, t1, -1

//--- bench/tb_ppuDecodeUnit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ppuDecodeUnit
    import ppuDecodePkg::*;
();

    localparam int CLK_PERIOD   = 20;
    localparam int MAX_PATTERNS = 64;

    logic        clk;
    logic        rst;
    logic        inValid;
    instrWord_t  inInstr;
    logic        inReady;
    logic        outValid;
    ctrlWord_t   outCtrl;
    logic        outUnknown;
    instrWord_t  outInstr;
    logic        outReady;

    logic [31:0] patMem [0:3*MAX_PATTERNS-1];  // instr, ctrl, unknown per pattern
    int          numPatterns;
    int          sb [$];  // pattern indices in flight, oldest first
    int          testList [$];
    int          checkCount;
    int          errCount;
    int          headIdx;
    integer      seed;

    ppuDecodeUnit i_ppuDecodeUnit (
        .clk        (clk),
        .rst        (rst),
        .inValid    (inValid),
        .inInstr    (inInstr),
        .inReady    (inReady),
        .outValid   (outValid),
        .outCtrl    (outCtrl),
        .outUnknown (outUnknown),
        .outInstr   (outInstr),
        .outReady   (outReady)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic instrWord_t patternInstr(input int idx);
        return patMem[3 * idx];
    endfunction

    function automatic ctrlWord_t patternCtrl(input int idx);
        return ctrlWord_t'(patMem[3 * idx + 1]);
    endfunction

    function automatic logic patternUnknown(input int idx);
        return patMem[3 * idx + 2][0];
    endfunction

    task automatic reportMismatch(input string sigName, input logic [31:0] expVal,
                                  input logic [31:0] actVal);
        $display("ERR %s expected %h got %h at %0t", sigName, expVal, actVal, $time);
        errCount++;
    endtask

    // values seen here are the ones transferred at the next rising edge
    always @(negedge clk) begin
        if (!rst && outValid && outReady) begin
            if (sb.size() == 0) begin
                $display("output transfer of %h with no item outstanding", outInstr);
                errCount++;
            end else begin
                headIdx = sb.pop_front();
                checkCount += 3;
                if (outInstr !== patternInstr(headIdx))
                    reportMismatch("outInstr", patternInstr(headIdx), outInstr);
                if (outCtrl !== patternCtrl(headIdx))
                    reportMismatch("outCtrl", patternCtrl(headIdx), outCtrl);
                if (outUnknown !== patternUnknown(headIdx))
                    reportMismatch("outUnknown", patternUnknown(headIdx), outUnknown);
            end
        end
    end

    // offers testList in order, outReady low for the first stallCycles cycles
    task automatic runStream(input string name, input bit jitter, input int stallCycles);
        int sent;
        int cycle;
        bit accepted;
        int errStart;
        int checkStart;
        sent = 0;
        cycle = 0;
        errStart = errCount;
        checkStart = checkCount;
        while (sent < testList.size() || sb.size() != 0) begin
            if (cycle < stallCycles)
                outReady = 1'b0;
            else if (jitter)
                outReady = ($random(seed) % 4) != 0;
            else
                outReady = 1'b1;
            if (!inValid && sent < testList.size() && (!jitter || $random(seed) % 3 != 0)) begin
                inValid = 1'b1;
                inInstr = patternInstr(testList[sent]);
            end
            @(negedge clk);
            if (cycle < stallCycles) begin
                checkCount++;
                if (sent >= 2 && inReady !== 1'b0)
                    reportMismatch("inReady", 32'd0, inReady);
                if (sent < 2 && inReady !== 1'b1)
                    reportMismatch("inReady", 32'd1, inReady);
                if (sent >= 1) begin  // head must sit unchanged
                    checkCount += 3;
                    if (outValid !== 1'b1)
                        reportMismatch("outValid", 32'd1, outValid);
                    if (outInstr !== patternInstr(testList[0]))
                        reportMismatch("outInstr", patternInstr(testList[0]), outInstr);
                    if (outCtrl !== patternCtrl(testList[0]))
                        reportMismatch("outCtrl", patternCtrl(testList[0]), outCtrl);
                end
            end
            accepted = inValid && inReady;
            if (accepted) begin
                sb.push_back(testList[sent]);
                sent++;
            end
            @(posedge clk);
            #2;
            if (accepted)
                inValid = 1'b0;
            cycle++;
        end
        $display("test %s: %0d checks, %0d errors", name, checkCount - checkStart,
                 errCount - errStart);
    endtask

    initial begin
        wait (numPatterns > 0);
        #((4 * numPatterns + 200) * CLK_PERIOD);
        $display("watchdog expired, output stalled with %0d items outstanding", sb.size());
        $display("Checks failed");
        $finish;
    end

    initial begin
        int loaded;
        int i;
        seed = 32'h3d0b;
        rst = 1'b1;
        inValid = 1'b0;
        inInstr = '0;
        outReady = 1'b0;
        checkCount = 0;
        errCount = 0;
        numPatterns = 0;
        $readmemh("bench/decode_patterns.txt", patMem);
        loaded = 0;
        while (loaded < MAX_PATTERNS && !$isunknown(patMem[3 * loaded]))
            loaded++;
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;
        @(negedge clk);
        checkCount += 2;
        if (outValid !== 1'b0)
            reportMismatch("outValid", 32'd0, outValid);
        if (inReady !== 1'b1)
            reportMismatch("inReady", 32'd1, inReady);
        $display("test reset: 2 checks, %0d errors", errCount);
        @(posedge clk);
        #2;
        if (loaded == 0) begin
            $display("no patterns could be read from bench/decode_patterns.txt");
            errCount++;
        end else begin
            numPatterns = loaded;
            for (i = 0; i < numPatterns; i++)
                if (patternUnknown(i) == 1'b0)
                    testList.push_back(i);
            runStream("supported", 1'b0, 0);
            testList.delete();
            for (i = 0; i < numPatterns; i++)
                if (patternInstr(i) == '0 || patternUnknown(i) == 1'b1)
                    testList.push_back(i);
            runStream("zero and unknown", 1'b0, 0);
            testList.delete();
            for (i = 1; i < 4 && i < numPatterns; i++)
                testList.push_back(i);
            runStream("back-pressure", 1'b0, 6);
            testList.delete();
            for (i = 0; i < numPatterns; i++)
                testList.push_back(i);
            runStream("random stream", 1'b1, 0);
        end
        $display("summary: %0d checks, %0d errors", checkCount, errCount);
        if (errCount == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- design/ppuDecodeUnit.sv
`timescale 1ns/1ps
`default_nettype none

module ppuDecodeUnit
    import ppuDecodePkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       inValid,
    input  instrWord_t inInstr,
    output logic       inReady,
    output logic       outValid,
    output ctrlWord_t  outCtrl,
    output logic       outUnknown,
    output instrWord_t outInstr,
    input  logic       outReady
);

    instrKind_e kind;
    ctrlWord_t  decCtrl;
    logic       decUnknown;

    instrClassifier i_instrClassifier (
        .instr (inInstr),
        .kind  (kind)
    );

    controlEncoder i_controlEncoder (
        .kind    (kind),
        .ctrl    (decCtrl),
        .unknown (decUnknown)
    );

    // decode is combinational, the buffer is the only pipeline stage
    idSkidBuffer i_idSkidBuffer (
        .clk        (clk),
        .rst        (rst),
        .inValid    (inValid),
        .inCtrl     (decCtrl),
        .inUnknown  (decUnknown),
        .inInstr    (inInstr),
        .inReady    (inReady),
        .outValid   (outValid),
        .outCtrl    (outCtrl),
        .outUnknown (outUnknown),
        .outInstr   (outInstr),
        .outReady   (outReady)
    );

endmodule

`default_nettype wire

//--- design/idSkidBuffer.sv
`timescale 1ns/1ps
`default_nettype none

module idSkidBuffer
    import ppuDecodePkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       inValid,
    input  ctrlWord_t  inCtrl,
    input  logic       inUnknown,
    input  instrWord_t inInstr,
    output logic       inReady,
    output logic       outValid,
    output ctrlWord_t  outCtrl,
    output logic       outUnknown,
    output instrWord_t outInstr,
    input  logic       outReady
);

    ctrlWord_t  ctrlMem [2];
    logic       unknownMem [2];
    instrWord_t instrMem [2];
    logic       wrPtr, rdPtr;  // one bit each, two slots
    logic [1:0] count, countNext;
    logic       pushEn, popEn;

    assign pushEn = inValid && inReady;
    assign popEn  = outValid && outReady;

    always_comb begin
        case ({pushEn, popEn})
            2'b10:   countNext = count + 2'd1;
            2'b01:   countNext = count - 2'd1;
            default: countNext = count;  // idle or push+pop together
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            count   <= '0;
            wrPtr   <= 1'b0;
            rdPtr   <= 1'b0;
            inReady <= 1'b1;
        end else begin
            count   <= countNext;
            inReady <= (countNext != 2'd2);  // registered, full at two
            if (pushEn) wrPtr <= ~wrPtr;
            if (popEn) rdPtr <= ~rdPtr;
        end
    end

    always_ff @(posedge clk) begin
        if (pushEn) begin
            ctrlMem[wrPtr]    <= inCtrl;
            unknownMem[wrPtr] <= inUnknown;
            instrMem[wrPtr]   <= inInstr;
        end
    end

    assign outValid   = (count != 2'd0);
    assign outCtrl    = ctrlMem[rdPtr];  // head entry
    assign outUnknown = unknownMem[rdPtr];
    assign outInstr   = instrMem[rdPtr];

    // stalled head must hold until the consumer takes it
    aHoldOnStall: assert property (@(posedge clk) disable iff (rst)
        (outValid && !outReady) |=> (outValid && $stable(outCtrl)
            && $stable(outUnknown) && $stable(outInstr)));

    aCountMax: assert property (@(posedge clk) disable iff (rst) count <= 2'd2);

    aIdleAfterReset: assert property (@(posedge clk) rst |=> !outValid);

endmodule

`default_nettype wire

//--- design/controlEncoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "ppu_defines.svh"

module controlEncoder
    import ppuDecodePkg::*;
(
    input  instrKind_e kind,
    output ctrlWord_t  ctrl,
    output logic       unknown
);

    aluOp_t   aluOp;
    srcOp_t   srcOp;
    destSel_t destSel;
    logic     memEnable, memSe, memRw;
    logic     taInstr, rfEnable, loadInstr, bInstr;
    logic     jump, condJump, rsAddrMux, addrMux;

    assign unknown = (kind == KIND_UNKNOWN);

    always_comb begin
        aluOp     = '0;
        srcOp     = '0;
        destSel   = `PPU_DEST_NONE;
        memEnable = 1'b0;
        memSe     = 1'b0;
        memRw     = 1'b0;
        taInstr   = 1'b0;
        rfEnable  = 1'b0;
        loadInstr = 1'b0;
        bInstr    = 1'b0;
        jump      = 1'b0;
        condJump  = 1'b0;
        rsAddrMux = 1'b0;
        addrMux   = 1'b0;
        case (kind)
            KIND_ADDIU: begin
                srcOp = 3'd4;  // sign-extended imm16
                rfEnable = 1'b1;
                destSel = `PPU_DEST_RT;
            end
            KIND_ADDU: begin
                rfEnable = 1'b1;
                destSel = `PPU_DEST_RD;
            end
            KIND_SUBU: begin
                aluOp = 4'd1;  // subtract
                rfEnable = 1'b1;
                destSel = `PPU_DEST_RD;
            end
            KIND_LB, KIND_LBU: begin
                srcOp = 3'd4;
                loadInstr = 1'b1;
                rfEnable = 1'b1;
                memSe = (kind == KIND_LB);  // lbu zero-extends
                memEnable = 1'b1;
                destSel = `PPU_DEST_RT;
            end
            KIND_SB, KIND_SD: begin
                memRw = 1'b1;  // write
                memEnable = 1'b1;
                destSel = `PPU_DEST_RT;
            end
            KIND_BGTZ: begin
                aluOp = 4'd10;
                bInstr = 1'b1;
                taInstr = 1'b1;
                rsAddrMux = 1'b1;
            end
            KIND_JAL: begin
                srcOp = 3'd3;
                aluOp = 4'd12;  // return address path
                rfEnable = 1'b1;
                taInstr = 1'b1;
                condJump = 1'b1;
                jump = 1'b1;
                destSel = `PPU_DEST_R31;
            end
            KIND_LUI: begin
                srcOp = 3'd5;
                aluOp = 4'd11;
                rfEnable = 1'b1;
                destSel = `PPU_DEST_RT;
            end
            KIND_JR: begin
                condJump = 1'b1;
                jump = 1'b1;
                destSel = `PPU_DEST_RS;
                rsAddrMux = 1'b1;
            end
            KIND_REGIMM: begin
                aluOp = 4'd10;
                bInstr = 1'b1;
                taInstr = 1'b1;
                condJump = 1'b1;
                destSel = `PPU_DEST_RS;
                rsAddrMux = 1'b1;
                addrMux = 1'b1;
            end
            KIND_BEQ: begin
                bInstr = 1'b1;
                taInstr = 1'b1;
                condJump = 1'b1;
                rsAddrMux = 1'b1;
                addrMux = 1'b1;
            end
            default: ;  // nop and unknown keep all zeros
        endcase
    end

    always_comb begin
        ctrl = '0;  // enable and mem size fields stay zero
        ctrl[`PPU_CB_MEM_ENABLE] = memEnable;
        ctrl[`PPU_CB_MEM_SE] = memSe;
        ctrl[`PPU_CB_MEM_RW] = memRw;
        ctrl[`PPU_CB_TA_INSTR] = taInstr;
        ctrl[`PPU_CB_RF_ENABLE] = rfEnable;
        ctrl[`PPU_CB_LOAD_INSTR] = loadInstr;
        ctrl[`PPU_CB_B_INSTR] = bInstr;
        ctrl[`PPU_CB_ALU_OP_HI:`PPU_CB_ALU_OP_LO] = aluOp;
        ctrl[`PPU_CB_SRC_OP_HI:`PPU_CB_SRC_OP_LO] = srcOp;
        ctrl[`PPU_CB_DEST_SEL_HI:`PPU_CB_DEST_SEL_LO] = destSel;
        ctrl[`PPU_CB_JUMP] = jump;
        ctrl[`PPU_CB_COND_JUMP] = condJump;
        ctrl[`PPU_CB_RS_ADDR_MUX] = rsAddrMux;
        ctrl[`PPU_CB_ADDR_MUX] = addrMux;
    end

    // only nop and unrecognised words leave ctrl all zero
    always_comb begin
        assert final ((unknown || kind == KIND_NOP) ? (ctrl == '0) : (ctrl != '0))
            else $error("ctrl %h does not fit kind %0d", ctrl, kind);
    end

endmodule

`default_nettype wire

//--- design/instrClassifier.sv
`timescale 1ns/1ps
`default_nettype none

`include "ppu_defines.svh"

module instrClassifier
    import ppuDecodePkg::*;
(
    input  instrWord_t instr,
    output instrKind_e kind
);

    opcode_t opcode;
    funct_t  funct;

    assign opcode = instr[`PPU_OPCODE_HI:`PPU_OPCODE_LO];
    assign funct  = instr[`PPU_FUNCT_HI:`PPU_FUNCT_LO];

    always_comb begin
        kind = KIND_UNKNOWN;  // anything not matched below
        if (instr == '0) begin
            kind = KIND_NOP;  // all-zero word, sll r0 is not decoded
        end else begin
            unique case (opcode)
                `PPU_OP_RTYPE: begin
                    unique case (funct)
                        `PPU_FN_ADDU: kind = KIND_ADDU;
                        `PPU_FN_SUBU: kind = KIND_SUBU;
                        `PPU_FN_JR:   kind = KIND_JR;
                        default:      kind = KIND_UNKNOWN;  // other r-type ops
                    endcase
                end
                `PPU_OP_REGIMM: kind = KIND_REGIMM;  // rt field not inspected
                `PPU_OP_BEQ:    kind = KIND_BEQ;
                `PPU_OP_ADDIU:  kind = KIND_ADDIU;
                `PPU_OP_LB:     kind = KIND_LB;
                `PPU_OP_LBU:    kind = KIND_LBU;
                `PPU_OP_SB:     kind = KIND_SB;
                `PPU_OP_SD:     kind = KIND_SD;
                `PPU_OP_BGTZ:   kind = KIND_BGTZ;
                `PPU_OP_JAL:    kind = KIND_JAL;
                `PPU_OP_LUI:    kind = KIND_LUI;
                default:        kind = KIND_UNKNOWN;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/ppuDecodePkg.sv
`default_nettype none

`include "ppu_defines.svh"

package ppuDecodePkg;

    typedef logic [`PPU_INSTR_W-1:0]    instrWord_t;
    typedef logic [`PPU_CTRL_W-1:0]     ctrlWord_t;  // packed decode result
    typedef logic [`PPU_OPCODE_W-1:0]   opcode_t;
    typedef logic [`PPU_FUNCT_W-1:0]    funct_t;
    typedef logic [`PPU_ALU_OP_W-1:0]   aluOp_t;
    typedef logic [`PPU_SRC_OP_W-1:0]   srcOp_t;
    typedef logic [`PPU_DEST_SEL_W-1:0] destSel_t;  // see PPU_DEST_* codes
    typedef logic [`PPU_MEM_SIZE_W-1:0] memSize_t;

    // one entry per supported instruction, plus catch-all
    typedef enum logic [3:0] {
        KIND_NOP, KIND_ADDIU, KIND_ADDU, KIND_SUBU,
        KIND_LB, KIND_LBU, KIND_SB, KIND_SD,
        KIND_BGTZ, KIND_BEQ, KIND_REGIMM, KIND_JAL,
        KIND_JR, KIND_LUI, KIND_UNKNOWN
    } instrKind_e;

endpackage

`default_nettype wire

//--- design/ppu_defines.svh
`ifndef PPU_DEFINES_SVH
`define PPU_DEFINES_SVH

// datapath widths
`define PPU_INSTR_W        32
`define PPU_CTRL_W         25
`define PPU_OPCODE_W       6
`define PPU_FUNCT_W        6
`define PPU_ALU_OP_W       4
`define PPU_SRC_OP_W       3
`define PPU_DEST_SEL_W     3
`define PPU_MEM_SIZE_W     2

// instruction field positions
`define PPU_OPCODE_HI      31
`define PPU_OPCODE_LO      26
`define PPU_FUNCT_HI       5
`define PPU_FUNCT_LO       0

// primary opcodes
`define PPU_OP_RTYPE       6'b000000
`define PPU_OP_REGIMM      6'b000001  // bgez/bltz family, rt selects
`define PPU_OP_BEQ         6'b000100  // also the unconditional b alias
`define PPU_OP_ADDIU       6'b001001
`define PPU_OP_LB          6'b100000
`define PPU_OP_LBU         6'b100100
`define PPU_OP_SB          6'b101000
`define PPU_OP_SD          6'b111111
`define PPU_OP_BGTZ        6'b000111
`define PPU_OP_JAL         6'b000011
`define PPU_OP_LUI         6'b001111

// r-type funct codes
`define PPU_FN_ADDU        6'b100001
`define PPU_FN_SUBU        6'b100011
`define PPU_FN_JR          6'b001000

// destination select encodings
`define PPU_DEST_NONE      3'd0
`define PPU_DEST_RS        3'd1
`define PPU_DEST_RT        3'd2
`define PPU_DEST_R31       3'd3
`define PPU_DEST_RD        3'd4

// control word bit positions
`define PPU_CB_ENABLE_LO   0
`define PPU_CB_ENABLE_HI   1
`define PPU_CB_MEM_ENABLE  2
`define PPU_CB_MEM_SE      3
`define PPU_CB_MEM_RW      4
`define PPU_CB_MEM_SIZE_LO 5
`define PPU_CB_MEM_SIZE_HI 6
`define PPU_CB_TA_INSTR    7
`define PPU_CB_RF_ENABLE   8
`define PPU_CB_LOAD_INSTR  9
`define PPU_CB_B_INSTR     10
`define PPU_CB_ALU_OP_LO   11
`define PPU_CB_ALU_OP_HI   14
`define PPU_CB_SRC_OP_LO   15
`define PPU_CB_SRC_OP_HI   17
`define PPU_CB_DEST_SEL_LO 18
`define PPU_CB_DEST_SEL_HI 20
`define PPU_CB_JUMP        21
`define PPU_CB_COND_JUMP   22
`define PPU_CB_RS_ADDR_MUX 23
`define PPU_CB_ADDR_MUX    24

`endif
